// ==== logic/lsu_consts.svh ====
/*
 * shared widths, operation codes, exception causes and buffer depths
 * op code: bit 3 store, bit 2 unsigned load, bits 1:0 size (0 byte, 1 half, 2 word)
 * buffer depths must be powers of two
 */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

`define LSU_XLEN   32
`define LSU_TID_W  3
`define LSU_OP_W   4

`define LSU_OP_LB  4'b0000
`define LSU_OP_LH  4'b0001
`define LSU_OP_LW  4'b0010
`define LSU_OP_LBU 4'b0100
`define LSU_OP_LHU 4'b0101
`define LSU_OP_SB  4'b1000
`define LSU_OP_SH  4'b1001
`define LSU_OP_SW  4'b1010

`define LSU_CAUSE_W             4
`define LSU_CAUSE_LD_MISALIGNED 4'd4
`define LSU_CAUSE_ST_MISALIGNED 4'd6

`define LSU_SB_DEPTH  2
`define LSU_WBQ_DEPTH 2

`endif

// ==== logic/lsu_pkg.sv ====
/*
 * types shared by the load/store unit
 * the word view is fixed at 32 bits, little endian lane order
 */
`default_nettype none

package lsu_pkg;

    // one memory word seen as byte lanes or as half-word lanes
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } data_word_u;

endpackage

`default_nettype wire

// ==== logic/lsu_req_if.sv ====
/*
 * issued memory operation from the stage register to both units
 * the operation stays stable until the owning unit pops it
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

interface lsu_req_if;
    logic                  valid;
    logic                  is_store;
    logic [`LSU_XLEN-1:0]  addr;
    // store data, already copied into every lane
    logic [`LSU_XLEN-1:0]  wdata;
    logic [3:0]            be;
    logic [1:0]            size;
    logic                  uns;
    logic [`LSU_TID_W-1:0] trans_id;
    logic                  misaligned;
    logic                  pop_ld;
    logic                  pop_st;

    modport issue (
        output valid, is_store, addr, wdata, be, size, uns, trans_id, misaligned,
        input  pop_ld, pop_st
    );
    modport load (
        input  valid, is_store, addr, size, uns, trans_id, misaligned,
        output pop_ld
    );
    modport store (
        input  valid, is_store, addr, wdata, be, trans_id, misaligned,
        output pop_st
    );
endinterface

`default_nettype wire

// ==== logic/lsu_wb_if.sv ====
/*
 * one unit's result towards the writeback merge, one-cycle strobe per result
 * full is only meaningful for the store side
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

interface lsu_wb_if;
    logic                    valid;
    logic [`LSU_TID_W-1:0]   trans_id;
    logic [`LSU_XLEN-1:0]    result;
    logic                    ex_valid;
    logic [`LSU_CAUSE_W-1:0] ex_cause;
    logic                    full;

    modport unit  (output valid, trans_id, result, ex_valid, ex_cause, input full);
    modport merge (input valid, trans_id, result, ex_valid, ex_cause, output full);
endinterface

`default_nettype wire

// ==== logic/lsu_issue.sv ====
/*
 * address generation, byte enables and misalignment check
 * ready_o is high only while the issue buffer is empty
 * an accepted operation reaches the stage register one cycle later
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_issue (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  logic                  valid_i,
    input  logic [`LSU_OP_W-1:0]  op_i,
    input  logic [`LSU_XLEN-1:0]  operand_a_i,
    input  logic [`LSU_XLEN-1:0]  imm_i,
    input  logic [`LSU_XLEN-1:0]  operand_b_i,
    input  logic [`LSU_TID_W-1:0] trans_id_i,
    output logic                  ready_o,
    lsu_req_if.issue              req
);
    import lsu_pkg::*;

    localparam int ENTRY_W = 9 + `LSU_TID_W + 2 * `LSU_XLEN;

    logic [`LSU_XLEN-1:0] vaddr;
    logic [1:0]           size;
    logic [3:0]           be;
    logic                 misaligned;
    data_word_u           wdata;
    logic [ENTRY_W-1:0]   entry_in;

    logic [ENTRY_W-1:0]   mem_q [2];
    logic                 wr_ptr_q, wr_ptr_n;
    logic                 rd_ptr_q, rd_ptr_n;
    logic [1:0]           cnt_q, cnt_n;
    logic                 push, pop;
    logic [ENTRY_W-1:0]   head;
    logic                 stage_valid_q;
    logic [ENTRY_W-1:0]   stage_q;

    // --------------------
    // address generation
    // --------------------
    // imm arrives sign extended
    assign vaddr = operand_a_i + imm_i;
    assign size  = op_i[1:0];

    always_comb begin
        be         = 4'b1111;
        misaligned = 1'b0;
        wdata      = operand_b_i;
        case (size)
            2'd0: begin
                be      = 4'b0001 << vaddr[1:0];
                wdata.b = {4{operand_b_i[7:0]}};
            end
            2'd1: begin
                be         = 4'b0011 << vaddr[1:0];
                misaligned = vaddr[0];
                wdata.h    = {2{operand_b_i[15:0]}};
            end
            default: misaligned = |vaddr[1:0];
        endcase
    end

    assign entry_in = {op_i[3], misaligned, op_i[2], size, be, trans_id_i, vaddr, wdata};

    // --------------------
    // issue buffer
    // --------------------
    assign ready_o = (cnt_q == 2'd0);
    assign push    = valid_i & ready_o;
    assign pop     = req.pop_ld | req.pop_st;

    always_comb begin
        wr_ptr_n = wr_ptr_q + push;
        rd_ptr_n = rd_ptr_q + pop;
        cnt_n    = cnt_q + {1'b0, push} - {1'b0, pop};
        if (flush_i) begin
            wr_ptr_n = 1'b0;
            rd_ptr_n = 1'b0;
            cnt_n    = 2'd0;
        end
    end

    // the next head feeds the stage, so a fresh op in an empty buffer goes straight through
    assign head = (push && wr_ptr_q == rd_ptr_n) ? entry_in : mem_q[rd_ptr_n];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q      <= 1'b0;
            rd_ptr_q      <= 1'b0;
            cnt_q         <= 2'd0;
            stage_valid_q <= 1'b0;
        end else begin
            wr_ptr_q      <= wr_ptr_n;
            rd_ptr_q      <= rd_ptr_n;
            cnt_q         <= cnt_n;
            stage_valid_q <= (cnt_n != 2'd0);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= entry_in;
        end
        stage_q <= head;
    end

    assign req.valid = stage_valid_q;
    assign {req.is_store, req.misaligned, req.uns, req.size, req.be, req.trans_id,
            req.addr, req.wdata} = stage_q;

endmodule

`default_nettype wire

// ==== logic/load_unit.sv ====
/*
 * load path, read data must arrive exactly one cycle after the request
 * stalls while a buffered store hits the same word
 * extension widths assume a 32-bit data path
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module load_unit (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    lsu_req_if.load              req,
    lsu_wb_if.unit               wb,
    output logic [`LSU_XLEN-3:0] ld_word_addr_o,
    input  logic                 st_match_i,
    output logic                 mem_rd_req_o,
    output logic [`LSU_XLEN-1:0] mem_rd_addr_o,
    input  logic [`LSU_XLEN-1:0] mem_rdata_i
);
    import lsu_pkg::*;

    logic                  ld_valid;
    logic                  rsp_valid_q;
    logic                  rsp_ex_q;
    logic [1:0]            rsp_off_q;
    logic [1:0]            rsp_size_q;
    logic                  rsp_uns_q;
    logic [`LSU_TID_W-1:0] rsp_tid_q;
    data_word_u            rdata;
    logic [7:0]            rbyte;
    logic [15:0]           rhalf;

    assign ld_valid       = req.valid & ~req.is_store;
    assign ld_word_addr_o = req.addr[`LSU_XLEN-1:2];

    // misaligned loads leave the stage without touching memory
    assign mem_rd_req_o  = ld_valid & ~req.misaligned & ~st_match_i;
    assign mem_rd_addr_o = {req.addr[`LSU_XLEN-1:2], 2'b00};
    assign req.pop_ld    = mem_rd_req_o | (ld_valid & req.misaligned);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req.pop_ld & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req.pop_ld) begin
            rsp_ex_q   <= req.misaligned;
            rsp_off_q  <= req.addr[1:0];
            rsp_size_q <= req.size;
            rsp_uns_q  <= req.uns;
            rsp_tid_q  <= req.trans_id;
        end
    end

    // --------------------
    // data extraction
    // --------------------
    assign rdata = mem_rdata_i;
    assign rbyte = rdata.b[rsp_off_q];
    assign rhalf = rdata.h[rsp_off_q[1]];

    always_comb begin
        case (rsp_size_q)
            2'd0:    wb.result = {{24{rbyte[7] & ~rsp_uns_q}}, rbyte};
            2'd1:    wb.result = {{16{rhalf[15] & ~rsp_uns_q}}, rhalf};
            default: wb.result = rdata;
        endcase
        if (rsp_ex_q) begin
            wb.result = '0;
        end
    end

    assign wb.valid    = rsp_valid_q;
    assign wb.trans_id = rsp_tid_q;
    assign wb.ex_valid = rsp_valid_q & rsp_ex_q;
    assign wb.ex_cause = rsp_ex_q ? `LSU_CAUSE_LD_MISALIGNED : '0;

endmodule

`default_nettype wire

// ==== logic/store_unit.sv ====
/*
 * store buffer, entries drain to memory only once committed
 * commit_i applies to the oldest uncommitted entry, flush drops uncommitted ones
 * LSU_SB_DEPTH must be a power of two
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module store_unit (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    lsu_req_if.store             req,
    lsu_wb_if.unit               wb,
    input  logic                 commit_i,
    output logic                 no_st_pending_o,
    input  logic [`LSU_XLEN-3:0] ld_word_addr_i,
    output logic                 st_match_o,
    output logic                 mem_wr_en_o,
    output logic [`LSU_XLEN-1:0] mem_wr_addr_o,
    output logic [`LSU_XLEN-1:0] mem_wr_data_o,
    output logic [3:0]           mem_wr_be_o
);
    import lsu_pkg::*;

    localparam int DEPTH = `LSU_SB_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [DEPTH-1:0]     valid_q, valid_n;
    logic [DEPTH-1:0]     cmt_q, cmt_n;
    logic [PTR_W-1:0]     wr_ptr_q, wr_ptr_n;
    logic [PTR_W-1:0]     rd_ptr_q, rd_ptr_n;
    logic [PTR_W-1:0]     cm_ptr_q, cm_ptr_n;
    logic [`LSU_XLEN-3:0] addr_q [DEPTH];
    logic [`LSU_XLEN-1:0] data_q [DEPTH];
    logic [3:0]           be_q [DEPTH];
    logic                 st_valid, accept, push, drain;
    data_word_u           lanes;
    logic [DEPTH-1:0]     hit;

    // a misaligned store needs a result slot but no buffer slot
    assign st_valid   = req.valid & req.is_store;
    assign accept     = st_valid & ~wb.full & ~flush_i & (req.misaligned | ~valid_q[wr_ptr_q]);
    assign push       = accept & ~req.misaligned;
    assign req.pop_st = accept;

    assign wb.valid    = accept;
    assign wb.trans_id = req.trans_id;
    assign wb.result   = '0;
    assign wb.ex_valid = accept & req.misaligned;
    assign wb.ex_cause = `LSU_CAUSE_ST_MISALIGNED;

    // keep only the enabled lanes
    always_comb begin
        lanes = req.wdata;
        for (int k = 0; k < 4; k++) begin
            if (!req.be[k]) begin
                lanes.b[k] = 8'h00;
            end
        end
    end

    // --------------------
    // drain and commit
    // --------------------
    assign drain         = valid_q[rd_ptr_q] & cmt_q[rd_ptr_q];
    assign mem_wr_en_o   = drain;
    assign mem_wr_addr_o = {addr_q[rd_ptr_q], 2'b00};
    assign mem_wr_data_o = data_q[rd_ptr_q];
    assign mem_wr_be_o   = be_q[rd_ptr_q];

    always_comb begin
        valid_n  = valid_q;
        cmt_n    = cmt_q;
        wr_ptr_n = wr_ptr_q;
        rd_ptr_n = rd_ptr_q;
        cm_ptr_n = cm_ptr_q;
        if (drain) begin
            valid_n[rd_ptr_q] = 1'b0;
            cmt_n[rd_ptr_q]   = 1'b0;
            rd_ptr_n          = rd_ptr_q + 1'b1;
        end
        if (commit_i && valid_q[cm_ptr_q] && !cmt_q[cm_ptr_q]) begin
            cmt_n[cm_ptr_q] = 1'b1;
            cm_ptr_n        = cm_ptr_q + 1'b1;
        end
        if (push) begin
            valid_n[wr_ptr_q] = 1'b1;
            wr_ptr_n          = wr_ptr_q + 1'b1;
        end
        // uncommitted entries are the tail starting at cm_ptr
        if (flush_i) begin
            valid_n  = valid_n & cmt_n;
            wr_ptr_n = cm_ptr_n;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            cmt_q    <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cm_ptr_q <= '0;
        end else begin
            valid_q  <= valid_n;
            cmt_q    <= cmt_n;
            wr_ptr_q <= wr_ptr_n;
            rd_ptr_q <= rd_ptr_n;
            cm_ptr_q <= cm_ptr_n;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            addr_q[wr_ptr_q] <= req.addr[`LSU_XLEN-1:2];
            data_q[wr_ptr_q] <= lanes;
            be_q[wr_ptr_q]   <= req.be;
        end
    end

    // word match against every live entry, blocks younger loads
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            hit[i] = valid_q[i] & (addr_q[i] == ld_word_addr_i);
        end
    end

    assign st_match_o      = |hit;
    assign no_st_pending_o = ~|valid_q;

endmodule

`default_nettype wire

// ==== logic/lsu_writeback.sv ====
/*
 * single writeback port, load results pass straight through
 * store results that collide wait in a small queue, flush empties it
 * LSU_WBQ_DEPTH must be a power of two
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_writeback (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    lsu_wb_if.merge                 ld_wb,
    lsu_wb_if.merge                 st_wb,
    output logic                    wb_valid_o,
    output logic [`LSU_TID_W-1:0]   wb_trans_id_o,
    output logic [`LSU_XLEN-1:0]    wb_result_o,
    output logic                    wb_ex_valid_o,
    output logic [`LSU_CAUSE_W-1:0] wb_ex_cause_o
);
    localparam int DEPTH   = `LSU_WBQ_DEPTH;
    localparam int PTR_W   = $clog2(DEPTH);
    localparam int ENTRY_W = `LSU_TID_W + `LSU_XLEN + 1 + `LSU_CAUSE_W;

    logic [ENTRY_W-1:0] q_mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q, rd_ptr_q;
    logic [PTR_W:0]     cnt_q;
    logic               q_empty, enq, deq;
    logic [ENTRY_W-1:0] st_entry, out_entry;

    assign q_empty  = (cnt_q == '0);
    assign st_entry = {st_wb.trans_id, st_wb.result, st_wb.ex_valid, st_wb.ex_cause};

    // a store result waits behind a load or behind older store results
    assign enq = st_wb.valid & (ld_wb.valid | ~q_empty);
    assign deq = ~ld_wb.valid & ~q_empty;

    assign st_wb.full = (cnt_q == (PTR_W + 1)'(DEPTH));
    assign ld_wb.full = 1'b0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (enq) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (deq) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            cnt_q <= cnt_q + {{PTR_W{1'b0}}, enq} - {{PTR_W{1'b0}}, deq};
        end
    end

    always_ff @(posedge clk_i) begin
        if (enq) begin
            q_mem[wr_ptr_q] <= st_entry;
        end
    end

    // --------------------
    // port select
    // --------------------
    always_comb begin
        out_entry = st_entry;
        if (ld_wb.valid) begin
            out_entry = {ld_wb.trans_id, ld_wb.result, ld_wb.ex_valid, ld_wb.ex_cause};
        end else if (!q_empty) begin
            out_entry = q_mem[rd_ptr_q];
        end
    end

    assign wb_valid_o = ld_wb.valid | st_wb.valid | ~q_empty;
    assign {wb_trans_id_o, wb_result_o, wb_ex_valid_o, wb_ex_cause_o} = out_entry;

endmodule

`default_nettype wire

// ==== logic/lsu_top.sv ====
/*
 * 32-bit load/store unit, physical address equals virtual address
 * lsu_valid_i may only be raised while lsu_ready_o is high
 * read data is expected one cycle after mem_rd_req_o, writes act at the edge
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    lsu_valid_i,
    input  logic [`LSU_OP_W-1:0]    lsu_op_i,
    input  logic [`LSU_XLEN-1:0]    lsu_operand_a_i,
    input  logic [`LSU_XLEN-1:0]    lsu_imm_i,
    input  logic [`LSU_XLEN-1:0]    lsu_operand_b_i,
    input  logic [`LSU_TID_W-1:0]   lsu_trans_id_i,
    output logic                    lsu_ready_o,
    input  logic                    commit_i,
    output logic                    no_st_pending_o,
    output logic                    wb_valid_o,
    output logic [`LSU_TID_W-1:0]   wb_trans_id_o,
    output logic [`LSU_XLEN-1:0]    wb_result_o,
    output logic                    wb_ex_valid_o,
    output logic [`LSU_CAUSE_W-1:0] wb_ex_cause_o,
    output logic                    mem_rd_req_o,
    output logic [`LSU_XLEN-1:0]    mem_rd_addr_o,
    input  logic [`LSU_XLEN-1:0]    mem_rdata_i,
    output logic                    mem_wr_en_o,
    output logic [`LSU_XLEN-1:0]    mem_wr_addr_o,
    output logic [`LSU_XLEN-1:0]    mem_wr_data_o,
    output logic [3:0]              mem_wr_be_o
);
    lsu_req_if req_if ();
    lsu_wb_if  ld_wb_if ();
    lsu_wb_if  st_wb_if ();

    logic [`LSU_XLEN-3:0] ld_word_addr;
    logic                 st_match;

    lsu_issue i_issue (
        .clk_i,
        .rst_ni,
        .flush_i,
        .valid_i     ( lsu_valid_i     ),
        .op_i        ( lsu_op_i        ),
        .operand_a_i ( lsu_operand_a_i ),
        .imm_i       ( lsu_imm_i       ),
        .operand_b_i ( lsu_operand_b_i ),
        .trans_id_i  ( lsu_trans_id_i  ),
        .ready_o     ( lsu_ready_o     ),
        .req         ( req_if          )
    );

    load_unit i_load_unit (
        .clk_i,
        .rst_ni,
        .flush_i,
        .req            ( req_if       ),
        .wb             ( ld_wb_if     ),
        .ld_word_addr_o ( ld_word_addr ),
        .st_match_i     ( st_match     ),
        .mem_rd_req_o,
        .mem_rd_addr_o,
        .mem_rdata_i
    );

    store_unit i_store_unit (
        .clk_i,
        .rst_ni,
        .flush_i,
        .req            ( req_if       ),
        .wb             ( st_wb_if     ),
        .commit_i,
        .no_st_pending_o,
        .ld_word_addr_i ( ld_word_addr ),
        .st_match_o     ( st_match     ),
        .mem_wr_en_o,
        .mem_wr_addr_o,
        .mem_wr_data_o,
        .mem_wr_be_o
    );

    lsu_writeback i_writeback (
        .clk_i,
        .rst_ni,
        .flush_i,
        .ld_wb ( ld_wb_if ),
        .st_wb ( st_wb_if ),
        .wb_valid_o,
        .wb_trans_id_o,
        .wb_result_o,
        .wb_ex_valid_o,
        .wb_ex_cause_o
    );

endmodule

`default_nettype wire

// ==== verification/lsu_asserts.sv ====
/*
 * protocol checks bound into lsu_top
 * checks are off while reset is low, except the quiet-after-reset check
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_asserts (
    input logic clk_i,
    input logic rst_ni,
    input logic flush_i,
    input logic valid_i,
    input logic ready_i,
    input logic rd_req_i,
    input logic wr_en_i,
    input logic wb_valid_i,
    input logic no_st_pending_i
);

    // issue side accepts only while the buffer is empty
    a_valid_needs_ready: assert property (
        @(posedge clk_i) disable iff (!rst_ni) valid_i |-> ready_i
    ) else $error("lsu_valid_i high while lsu_ready_o is low");

    // read data is consumed one cycle after the request
    a_read_then_wb: assert property (
        @(posedge clk_i) disable iff (!rst_ni) (rd_req_i && !flush_i) |=> wb_valid_i
    ) else $error("no writeback one cycle after a memory read");

    // a write drains a store that was already buffered the cycle before
    a_no_write_when_idle: assert property (
        @(posedge clk_i) disable iff (!rst_ni) no_st_pending_i |=> !wr_en_i
    ) else $error("memory write right after the store buffer was empty");

    a_quiet_after_reset: assert property (
        @(posedge clk_i) $rose(rst_ni) |->
            (!wb_valid_i && !rd_req_i && !wr_en_i && ready_i && no_st_pending_i)
    ) else $error("outputs not idle after reset");

endmodule

bind lsu_top lsu_asserts u_asserts (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .flush_i         ( flush_i         ),
    .valid_i         ( lsu_valid_i     ),
    .ready_i         ( lsu_ready_o     ),
    .rd_req_i        ( mem_rd_req_o    ),
    .wr_en_i         ( mem_wr_en_o     ),
    .wb_valid_i      ( wb_valid_o      ),
    .no_st_pending_i ( no_st_pending_o )
);

`default_nettype wire

// ==== verification/lsu_tb.sv ====
/*
 * stimulus and expected results for lsu_top come from lsu_input.txt
 * one operation in flight at a time
 * run from the project root so the data file path resolves
 * memory model has 256 words and higher address bits alias
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_consts.svh"

module lsu_tb;
    localparam int CLK_PERIOD      = 4;
    localparam int FIELDS          = 8;
    localparam int MAX_LINES       = 64;
    localparam int HOLD_CYCLES     = 10;
    localparam int CYCLES_PER_LINE = 50;

    // line kinds of the data file
    localparam logic [31:0] KIND_END    = 32'd0;
    localparam logic [31:0] KIND_OP     = 32'd1;
    localparam logic [31:0] KIND_COMMIT = 32'd2;
    localparam logic [31:0] KIND_FLUSH  = 32'd3;
    localparam logic [31:0] KIND_HELD   = 32'd4;

    logic                    clk_i;
    logic                    rst_ni;
    logic                    flush_i;
    logic                    lsu_valid_i;
    logic [`LSU_OP_W-1:0]    lsu_op_i;
    logic [`LSU_XLEN-1:0]    lsu_operand_a_i;
    logic [`LSU_XLEN-1:0]    lsu_imm_i;
    logic [`LSU_XLEN-1:0]    lsu_operand_b_i;
    logic [`LSU_TID_W-1:0]   lsu_trans_id_i;
    logic                    lsu_ready_o;
    logic                    commit_i;
    logic                    no_st_pending_o;
    logic                    wb_valid_o;
    logic [`LSU_TID_W-1:0]   wb_trans_id_o;
    logic [`LSU_XLEN-1:0]    wb_result_o;
    logic                    wb_ex_valid_o;
    logic [`LSU_CAUSE_W-1:0] wb_ex_cause_o;
    logic                    mem_rd_req_o;
    logic [`LSU_XLEN-1:0]    mem_rd_addr_o;
    logic [`LSU_XLEN-1:0]    mem_rdata_i = '0;
    logic                    mem_wr_en_o;
    logic [`LSU_XLEN-1:0]    mem_wr_addr_o;
    logic [`LSU_XLEN-1:0]    mem_wr_data_o;
    logic [3:0]              mem_wr_be_o;

    logic [31:0]             mem [256];
    int                      rd_count;
    logic [31:0]             stim [MAX_LINES*FIELDS];
    int                      n_lines;

    // a load that waits for a store commit
    logic                    held_pending;
    logic [`LSU_TID_W-1:0]   held_tid;
    logic [31:0]             held_res;

    lsu_top dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------
    // memory model
    // --------------------
    // every byte of the word mixes in the full word index
    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {8'hF0 ^ idx, 8'h70 ^ idx, 8'h10 ^ idx, 8'h90 ^ idx};
    endfunction

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= fill_word(8'(i));
            end
            rd_count <= 0;
        end else begin
            if (mem_rd_req_o) begin
                mem_rdata_i <= mem[mem_rd_addr_o[9:2]];
                rd_count    <= rd_count + 1;
            end
            if (mem_wr_en_o) begin
                for (int k = 0; k < 4; k++) begin
                    if (mem_wr_be_o[k]) begin
                        mem[mem_wr_addr_o[9:2]][8*k +: 8] <= mem_wr_data_o[8*k +: 8];
                    end
                end
            end
        end
    end

    // --------------------
    // reporting
    // --------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        abort_run($sformatf("Fail at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, exp));
    endtask

    // --------------------
    // drivers
    // --------------------
    task automatic drive_op(input logic [`LSU_OP_W-1:0] op, input logic [31:0] a,
                            input logic [31:0] imm, input logic [31:0] b,
                            input logic [`LSU_TID_W-1:0] tid);
        @(negedge clk_i);
        while (!lsu_ready_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        lsu_valid_i     <= 1'b1;
        lsu_op_i        <= op;
        lsu_operand_a_i <= a;
        lsu_imm_i       <= imm;
        lsu_operand_b_i <= b;
        lsu_trans_id_i  <= tid;
        @(posedge clk_i);
        lsu_valid_i     <= 1'b0;
    endtask

    task automatic pulse_commit();
        @(posedge clk_i);
        commit_i <= 1'b1;
        @(posedge clk_i);
        commit_i <= 1'b0;
    endtask

    task automatic pulse_flush();
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        @(negedge clk_i);
    endtask

    // waits for the result with this id until the watchdog fires
    task automatic check_writeback(input logic [`LSU_TID_W-1:0] tid, input logic [31:0] exp_res,
                                   input logic [`LSU_CAUSE_W-1:0] exp_cause);
        @(negedge clk_i);
        while (!(wb_valid_o && wb_trans_id_o == tid)) begin
            @(negedge clk_i);
        end
        assert (wb_ex_valid_o == (exp_cause != '0))
            else report_mismatch("wb_ex_valid_o", 32'(wb_ex_valid_o), 32'(exp_cause != '0));
        if (exp_cause != '0) begin
            assert (wb_ex_cause_o == exp_cause)
                else report_mismatch("wb_ex_cause_o", 32'(wb_ex_cause_o), 32'(exp_cause));
        end else begin
            assert (wb_result_o == exp_res)
                else report_mismatch("wb_result_o", wb_result_o, exp_res);
        end
    endtask

    task automatic run_line(input int idx);
        logic [31:0]             kind;
        logic [`LSU_OP_W-1:0]    op;
        logic [31:0]             a;
        logic [31:0]             imm;
        logic [31:0]             b;
        logic [`LSU_TID_W-1:0]   tid;
        logic [31:0]             exp_res;
        logic [`LSU_CAUSE_W-1:0] cause;
        int                      rd_before;
        logic                    idle_before;
        kind    = stim[idx*FIELDS];
        op      = stim[idx*FIELDS+1][`LSU_OP_W-1:0];
        a       = stim[idx*FIELDS+2];
        imm     = stim[idx*FIELDS+3];
        b       = stim[idx*FIELDS+4];
        tid     = stim[idx*FIELDS+5][`LSU_TID_W-1:0];
        exp_res = stim[idx*FIELDS+6];
        cause   = stim[idx*FIELDS+7][`LSU_CAUSE_W-1:0];
        case (kind)
            KIND_OP: begin
                rd_before   = rd_count;
                idle_before = no_st_pending_o;
                drive_op(op, a, imm, b, tid);
                check_writeback(tid, exp_res, cause);
                // an exception reads no memory and leaves the store buffer empty
                if (cause != '0) begin
                    @(negedge clk_i);
                    assert (rd_count == rd_before)
                        else report_mismatch("rd_count", 32'(rd_count), 32'(rd_before));
                    assert (!idle_before || no_st_pending_o)
                        else report_mismatch("no_st_pending_o", 32'(no_st_pending_o), 32'd1);
                end
            end
            KIND_HELD: begin
                drive_op(op, a, imm, b, tid);
                repeat (HOLD_CYCLES) begin
                    @(negedge clk_i);
                    assert (!(wb_valid_o && wb_trans_id_o == tid))
                        else abort_run("load wrote back before the buffered store was committed");
                end
                held_pending = 1'b1;
                held_tid     = tid;
                held_res     = exp_res;
            end
            KIND_COMMIT: begin
                pulse_commit();
                if (held_pending) begin
                    check_writeback(held_tid, held_res, '0);
                    held_pending = 1'b0;
                end
            end
            KIND_FLUSH: begin
                pulse_flush();
                assert (no_st_pending_o)
                    else report_mismatch("no_st_pending_o", 32'(no_st_pending_o), 32'd1);
            end
            default: abort_run("unknown line kind in the stimulus file");
        endcase
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        rst_ni          <= 1'b0;
        flush_i         <= 1'b0;
        lsu_valid_i     <= 1'b0;
        lsu_op_i        <= '0;
        lsu_operand_a_i <= '0;
        lsu_imm_i       <= '0;
        lsu_operand_b_i <= '0;
        lsu_trans_id_i  <= '0;
        commit_i        <= 1'b0;
        held_pending    = 1'b0;
        for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
            stim[i] = '0;
        end
        $readmemh("verification/lsu_input.txt", stim);
        while (n_lines < MAX_LINES && stim[n_lines*FIELDS] != KIND_END) begin
            n_lines++;
        end
        if (n_lines == 0) begin
            abort_run("stimulus file is missing or holds no lines");
        end
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int line = 0; line < n_lines; line++) begin
            run_line(line);
        end
        repeat (4) @(posedge clk_i);
        if (held_pending) begin
            abort_run("a held load was never released by a commit");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

    // budget scales with the number of stimulus lines
    initial begin
        @(posedge rst_ni);
        repeat (n_lines * CYCLES_PER_LINE + 10) @(posedge clk_i);
        abort_run("timeout: the run did not finish within its cycle budget");
    end

endmodule

`default_nettype wire

// ==== verification/lsu_input.txt ====
// kind op operand_a imm operand_b trans_id expected_result expected_cause (all hex)
// kind: 1 op, 2 commit, 3 flush, 4 load held until the next commit, 0 end
1 A 00000080 00000000 12345678 1 00000000 0
2 0 00000000 00000000 00000000 0 00000000 0
1 2 00000080 00000000 00000000 2 12345678 0
// byte and half lanes of word 0x40, fill value e0600080
1 0 00000040 00000000 00000000 3 FFFFFF80 0
1 4 00000040 00000000 00000000 4 00000080 0
1 0 00000040 00000001 00000000 5 00000000 0
1 4 00000040 00000002 00000000 6 00000060 0
1 0 00000044 FFFFFFFF 00000000 7 FFFFFFE0 0
1 4 00000040 00000003 00000000 0 000000E0 0
1 0 00000040 00000002 00000000 5 00000060 0
1 1 00000040 00000000 00000000 1 00000080 0
1 1 00000040 00000002 00000000 2 FFFFE060 0
1 5 00000040 00000002 00000000 3 0000E060 0
1 5 00000044 00000000 00000000 4 00000181 0
// misaligned accesses
1 1 00000040 00000001 00000000 6 00000000 4
1 2 00000040 00000002 00000000 7 00000000 4
1 9 00000040 00000003 00001111 0 00000000 6
1 A 00000040 00000001 22222222 1 00000000 6
// partial stores into word 0x84, fill value d15131b1
1 8 00000084 00000001 000000AB 2 00000000 0
2 0 00000000 00000000 00000000 0 00000000 0
1 2 00000084 00000000 00000000 3 D151ABB1 0
1 9 00000084 00000002 0000CDEF 4 00000000 0
2 0 00000000 00000000 00000000 0 00000000 0
1 2 00000084 00000000 00000000 5 CDEFABB1 0
1 0 00000084 00000001 00000000 6 FFFFFFAB 0
// load behind an uncommitted store
1 A 00000088 00000000 CAFEF00D 7 00000000 0
4 2 00000088 00000000 00000000 0 CAFEF00D 0
2 0 00000000 00000000 00000000 0 00000000 0
// flushed store, old value d35333b3 remains
1 A 0000008C 00000000 0BADBEEF 1 00000000 0
3 0 00000000 00000000 00000000 0 00000000 0
1 2 0000008C 00000000 00000000 2 D35333B3 0
0 0 00000000 00000000 00000000 0 00000000 0

// ==== sources.f ====
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_req_if.sv
logic/lsu_wb_if.sv
logic/lsu_issue.sv
logic/load_unit.sv
logic/store_unit.sv
logic/lsu_writeback.sv
logic/lsu_top.sv
verification/lsu_asserts.sv
verification/lsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := lsu_tb
FILELIST  := sources.f
VFLAGS    := --binary --timing --assert -Wno-fatal
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := CHECKS FAILED
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
